// ==== hdl/rdcache_pkg.sv ====
// read cache shared definitions
package rdcache_pkg;

  ////////////////////
  // geometry
  ////////////////////

  // word address and data width
  localparam int ADDR_W = 16;
  localparam int WORD_W = 32;
  // line layout
  localparam int OFF_W          = 2;
  localparam int WORDS_PER_LINE = 1 << OFF_W;
  localparam int IDX_W          = 4;
  localparam int NUM_LINES      = 1 << IDX_W;
  localparam int TAG_W          = ADDR_W - IDX_W - OFF_W;

  // inclusive cacheable window, word addresses
  localparam logic [ADDR_W-1:0] CACHEABLE_BASE  = 16'h0000;
  localparam logic [ADDR_W-1:0] CACHEABLE_LIMIT = 16'h7FFF;

  ////////////////////
  // payloads
  ////////////////////

  typedef struct packed {
    logic [ADDR_W-1:0] addr;
  } core_req_t;

  typedef struct packed {
    logic [WORD_W-1:0] rdata;
  } core_rsp_t;

  // nc set for an uncached single-word fetch
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic              nc;
  } miss_req_t;

  typedef struct packed {
    logic             valid;
    logic [TAG_W-1:0] tag;
  } tag_entry_t;

  typedef struct packed {
    logic [WORDS_PER_LINE-1:0][WORD_W-1:0] words;
  } line_t;

  // address split: tag | index | offset
  function automatic logic [TAG_W-1:0] addr_tag(input logic [ADDR_W-1:0] a);
    return a[ADDR_W-1 -: TAG_W];
  endfunction

  function automatic logic [IDX_W-1:0] addr_idx(input logic [ADDR_W-1:0] a);
    return a[OFF_W +: IDX_W];
  endfunction

  function automatic logic [OFF_W-1:0] addr_off(input logic [ADDR_W-1:0] a);
    return a[OFF_W-1:0];
  endfunction

  function automatic logic is_cacheable(input logic [ADDR_W-1:0] a);
    return (a >= CACHEABLE_BASE) && (a <= CACHEABLE_LIMIT);
  endfunction

endpackage

// ==== hdl/rdcache_beat_cnt.sv ====
// refill beat counter
`timescale 1ns/100ps

module rdcache_beat_cnt (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          clr_i,
  input  logic                          inc_i,
  output logic [rdcache_pkg::OFF_W-1:0] beat_o,
  output logic                          last_o
);
  import rdcache_pkg::*;

  logic [OFF_W-1:0] beat_q;

  // clear wins over increment
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      beat_q <= '0;
    end else if (clr_i) begin
      beat_q <= '0;
    end else if (inc_i) begin
      beat_q <= beat_q + 1'b1;
    end
  end

  assign beat_o = beat_q;
  // final word of the line
  assign last_o = (beat_q == OFF_W'(WORDS_PER_LINE - 1));

endmodule

// ==== hdl/rdcache_array.sv ====
// cache storage array
`timescale 1ns/100ps

module rdcache_array #(
  parameter type         entry_t = logic [31:0],
  parameter int unsigned DEPTH   = rdcache_pkg::NUM_LINES
) (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          rd_i,
  input  logic                          wr_i,
  input  logic [rdcache_pkg::IDX_W-1:0] idx_i,
  input  entry_t                        wdata_i,
  output entry_t                        rdata_o
);

  entry_t mem_q [DEPTH];
  entry_t rdata_q;

  // cleared on reset, so tag valid bits start low
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < DEPTH; i++) begin
        mem_q[i] <= '0;
      end
      rdata_q <= '0;
    end else begin
      if (wr_i) begin
        mem_q[idx_i] <= wdata_i;
      end
      // registered read, output holds between reads
      if (rd_i) begin
        rdata_q <= mem_q[idx_i];
      end
    end
  end

  assign rdata_o = rdata_q;

  a_rd_wr_excl: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(rd_i && wr_i))
    else $error("array read and write in same cycle");

endmodule

// ==== hdl/rdcache_ctrl.sv ====
// read cache controller
`timescale 1ns/100ps

module rdcache_ctrl (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  input  logic                             cache_en_i,
  // four-phase core port
  input  logic                             core_req_i,
  input  rdcache_pkg::core_req_t           core_req_data_i,
  output logic                             core_ack_o,
  output rdcache_pkg::core_rsp_t           core_rsp_o,
  // array read side
  input  rdcache_pkg::tag_entry_t          tag_rdata_i,
  input  rdcache_pkg::line_t               line_rdata_i,
  output logic                             arr_rd_o,
  output logic [rdcache_pkg::IDX_W-1:0]    arr_idx_o,
  // four-phase miss unit port
  output logic                             miss_req_o,
  output rdcache_pkg::miss_req_t           miss_req_data_o,
  input  logic                             miss_ack_i,
  input  logic [rdcache_pkg::WORD_W-1:0]   miss_rdata_i
);
  import rdcache_pkg::*;

  typedef enum logic [2:0] {
    IDLE,
    LOOKUP,
    MISS_REQ,
    MISS_WAIT,
    RESPOND,
    RELEASE
  } state_e;

  state_e            state_d, state_q;
  logic              ack_d, ack_q;
  logic              miss_req_d, miss_req_q;
  logic [ADDR_W-1:0] addr_d, addr_q;
  logic              nc_d, nc_q;
  logic [WORD_W-1:0] rdata_d, rdata_q;
  logic              lookup_nc;
  logic              hit;

  ////////////////////
  // lookup
  ////////////////////

  // uncached when outside the window or cache off
  assign lookup_nc = !cache_en_i || !is_cacheable(addr_q);
  // arrays hold the latched index one cycle after IDLE
  assign hit = !lookup_nc && tag_rdata_i.valid
               && (tag_rdata_i.tag == addr_tag(addr_q));

  // read straight from the core address so data lands in LOOKUP
  assign arr_rd_o  = (state_q == IDLE) && core_req_i;
  assign arr_idx_o = addr_idx(core_req_data_i.addr);

  assign core_ack_o       = ack_q;
  assign core_rsp_o.rdata = rdata_q;
  assign miss_req_o       = miss_req_q;
  assign miss_req_data_o  = '{addr: addr_q, nc: nc_q};

  ////////////////////
  // fsm
  ////////////////////

  always_comb begin
    state_d    = state_q;
    ack_d      = ack_q;
    miss_req_d = miss_req_q;
    addr_d     = addr_q;
    nc_d       = nc_q;
    rdata_d    = rdata_q;
    unique case (state_q)
      IDLE: begin
        if (core_req_i) begin
          addr_d  = core_req_data_i.addr;
          state_d = LOOKUP;
        end
      end
      LOOKUP: begin
        nc_d = lookup_nc;
        if (hit) begin
          // select the word by offset and register the ack
          rdata_d = line_rdata_i.words[addr_off(addr_q)];
          ack_d   = 1'b1;
          state_d = RELEASE;
        end else begin
          state_d = MISS_REQ;
        end
      end
      MISS_REQ: begin
        miss_req_d = 1'b1;
        state_d    = MISS_WAIT;
      end
      MISS_WAIT: begin
        // refill writes land while the miss handshake runs
        if (miss_req_q && miss_ack_i) begin
          rdata_d    = miss_rdata_i;
          miss_req_d = 1'b0;
        end else if (!miss_req_q && !miss_ack_i) begin
          state_d = RESPOND;
        end
      end
      RESPOND: begin
        ack_d   = 1'b1;
        state_d = RELEASE;
      end
      RELEASE: begin
        // hold ack until the core drops req
        if (!core_req_i) begin
          ack_d   = 1'b0;
          state_d = IDLE;
        end
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= IDLE;
      ack_q      <= 1'b0;
      miss_req_q <= 1'b0;
    end else begin
      state_q    <= state_d;
      ack_q      <= ack_d;
      miss_req_q <= miss_req_d;
    end
  end

  // request payload
  always_ff @(posedge clk_i) begin
    addr_q  <= addr_d;
    nc_q    <= nc_d;
    rdata_q <= rdata_d;
  end

  ////////////////////
  // assertions
  ////////////////////

  // miss unit writes only inside an open miss handshake
  a_rd_no_wr: assert property (@(posedge clk_i) disable iff (!rst_ni)
    arr_rd_o |-> !miss_req_o && !miss_ack_i)
    else $error("array read during miss handshake");

  // ack only rises on an edge that saw the request high
  a_ack_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(core_ack_o) |-> $past(core_req_i))
    else $error("core ack without request");

endmodule

// ==== hdl/rdcache_miss_unit.sv ====
// cache miss unit
`timescale 1ns/100ps

module rdcache_miss_unit (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  // from controller, four-phase
  input  logic                           miss_req_i,
  input  rdcache_pkg::miss_req_t         miss_req_data_i,
  output logic                           miss_ack_o,
  output logic [rdcache_pkg::WORD_W-1:0] miss_rdata_o,
  // memory side, four-phase
  output logic                           mem_req_o,
  output logic [rdcache_pkg::ADDR_W-1:0] mem_addr_o,
  input  logic                           mem_ack_i,
  input  logic [rdcache_pkg::WORD_W-1:0] mem_rdata_i,
  // array write side
  output logic                           arr_wr_o,
  output logic [rdcache_pkg::IDX_W-1:0]  arr_idx_o,
  output rdcache_pkg::tag_entry_t        tag_wdata_o,
  output rdcache_pkg::line_t             line_wdata_o
);
  import rdcache_pkg::*;

  typedef enum logic [2:0] {
    M_IDLE,
    M_REQ,
    M_DROP,
    M_WRITE,
    M_ACK
  } mstate_e;

  mstate_e          state_d, state_q;
  miss_req_t        req_q;
  line_t            line_q;
  logic [OFF_W-1:0] beat;
  logic             last;
  logic             start;
  logic             beat_done;

  // wait for the previous mem ack to drop before starting
  assign start     = (state_q == M_IDLE) && miss_req_i && !mem_ack_i;
  assign beat_done = (state_q == M_DROP) && !mem_ack_i;

  rdcache_beat_cnt i_beat_cnt (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .clr_i  (start),
    .inc_i  (beat_done),
    .beat_o (beat),
    .last_o (last)
  );

  ////////////////////
  // memory side
  ////////////////////

  assign mem_req_o  = (state_q == M_REQ);
  // nc: the word itself, refill: line base plus beat
  assign mem_addr_o = req_q.nc ? req_q.addr : {req_q.addr[ADDR_W-1:OFF_W], beat};

  // array write and miss answer
  assign arr_wr_o     = (state_q == M_WRITE);
  assign arr_idx_o    = addr_idx(req_q.addr);
  assign tag_wdata_o  = '{valid: 1'b1, tag: addr_tag(req_q.addr)};
  assign line_wdata_o = line_q;
  assign miss_ack_o   = (state_q == M_ACK);
  assign miss_rdata_o = line_q.words[addr_off(req_q.addr)];

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      M_IDLE: begin
        if (start) begin
          state_d = M_REQ;
        end
      end
      M_REQ: begin
        if (mem_ack_i) begin
          if (req_q.nc) begin
            state_d = M_ACK;
          end else if (last) begin
            state_d = M_WRITE;
          end else begin
            state_d = M_DROP;
          end
        end
      end
      M_DROP: begin
        if (!mem_ack_i) begin
          state_d = M_REQ;
        end
      end
      M_WRITE: begin
        state_d = M_ACK;
      end
      M_ACK: begin
        if (!miss_req_i) begin
          state_d = M_IDLE;
        end
      end
      default: begin
        state_d = M_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= M_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // line buffer slot follows the low bits of the beat address
  always_ff @(posedge clk_i) begin
    if (start) begin
      req_q <= miss_req_data_i;
    end
    if ((state_q == M_REQ) && mem_ack_i) begin
      line_q.words[mem_addr_o[OFF_W-1:0]] <= mem_rdata_i;
    end
  end

  a_addr_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem_req_o |=> !mem_req_o || $stable(mem_addr_o))
    else $error("mem address changed during request");

endmodule

// ==== hdl/rdcache_top.sv ====
// read cache top level
`timescale 1ns/100ps

module rdcache_top (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic                           cache_en_i,
  input  logic                           core_req_i,
  input  rdcache_pkg::core_req_t         core_req_data_i,
  output logic                           core_ack_o,
  output rdcache_pkg::core_rsp_t         core_rsp_o,
  output logic                           mem_req_o,
  output logic [rdcache_pkg::ADDR_W-1:0] mem_addr_o,
  input  logic                           mem_ack_i,
  input  logic [rdcache_pkg::WORD_W-1:0] mem_rdata_i
);
  import rdcache_pkg::*;

  logic              arr_rd, arr_wr;
  logic [IDX_W-1:0]  rd_idx, wr_idx;
  tag_entry_t        tag_rdata, tag_wdata;
  line_t             line_rdata, line_wdata;
  logic              miss_req, miss_ack;
  miss_req_t         miss_req_data;
  logic [WORD_W-1:0] miss_rdata;

  rdcache_ctrl i_ctrl (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .cache_en_i      (cache_en_i),
    .core_req_i      (core_req_i),
    .core_req_data_i (core_req_data_i),
    .core_ack_o      (core_ack_o),
    .core_rsp_o      (core_rsp_o),
    .tag_rdata_i     (tag_rdata),
    .line_rdata_i    (line_rdata),
    .arr_rd_o        (arr_rd),
    .arr_idx_o       (rd_idx),
    .miss_req_o      (miss_req),
    .miss_req_data_o (miss_req_data),
    .miss_ack_i      (miss_ack),
    .miss_rdata_i    (miss_rdata)
  );

  // write strobe steers the shared index
  rdcache_array #(
    .entry_t (tag_entry_t),
    .DEPTH   (NUM_LINES)
  ) i_tag_array (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .rd_i    (arr_rd),
    .wr_i    (arr_wr),
    .idx_i   (arr_wr ? wr_idx : rd_idx),
    .wdata_i (tag_wdata),
    .rdata_o (tag_rdata)
  );

  rdcache_array #(
    .entry_t (line_t),
    .DEPTH   (NUM_LINES)
  ) i_data_array (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .rd_i    (arr_rd),
    .wr_i    (arr_wr),
    .idx_i   (arr_wr ? wr_idx : rd_idx),
    .wdata_i (line_wdata),
    .rdata_o (line_rdata)
  );

  rdcache_miss_unit i_miss_unit (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .miss_req_i      (miss_req),
    .miss_req_data_i (miss_req_data),
    .miss_ack_o      (miss_ack),
    .miss_rdata_o    (miss_rdata),
    .mem_req_o       (mem_req_o),
    .mem_addr_o      (mem_addr_o),
    .mem_ack_i       (mem_ack_i),
    .mem_rdata_i     (mem_rdata_i),
    .arr_wr_o        (arr_wr),
    .arr_idx_o       (wr_idx),
    .tag_wdata_o     (tag_wdata),
    .line_wdata_o    (line_wdata)
  );

endmodule

// ==== testbench/tb_mem_model.sv ====
// four-phase memory model
`timescale 1ns/100ps

module tb_mem_model #(
  parameter logic [31:0] SEED         = 32'ha35661e0,
  parameter int          DROP_TIMEOUT = 1000
) (
  input  logic        clk_i,
  input  logic        mem_req_i,
  input  logic [15:0] mem_addr_i,
  output logic        mem_ack_o,
  output logic [31:0] mem_rdata_o,
  output int          beats_o,
  output logic        stuck_o
);

  integer      seed;
  // beat addresses in arrival order
  logic [15:0] addr_log [0:1023];

  initial begin
    int          delay;
    int          n;
    logic [15:0] addr;
    seed        = SEED;
    mem_ack_o   = 1'b0;
    mem_rdata_o = '0;
    beats_o     = 0;
    stuck_o     = 1'b0;
    forever begin
      // inputs sampled at the edge, outputs 2 ns later
      @(posedge clk_i);
      if (mem_req_i && !mem_ack_o) begin
        addr  = mem_addr_i;
        delay = {$random(seed)} % 4;
        repeat (delay) @(posedge clk_i);
        #2;
        // data pattern: address high, inverted address low
        mem_rdata_o = {addr, ~addr};
        mem_ack_o   = 1'b1;
        addr_log[beats_o % 1024] = addr;
        n = 0;
        do begin
          @(posedge clk_i);
          n++;
        end while (mem_req_i && n < DROP_TIMEOUT);
        if (mem_req_i) begin
          // requester never released
          stuck_o = 1'b1;
        end else begin
          #2;
          mem_ack_o = 1'b0;
          beats_o   = beats_o + 1;
        end
      end
    end
  end

endmodule

// ==== testbench/tb_rdcache.sv ====
// read cache testbench
`timescale 1ns/100ps

module tb_rdcache;
  import rdcache_pkg::*;

  localparam logic [31:0] SEED    = 32'ha35661e0;
  localparam int          TIMEOUT = 200;

  logic              clk;
  logic              rst_n;
  logic              cache_en;
  logic              core_req;
  core_req_t         core_req_data;
  logic              core_ack;
  core_rsp_t         core_rsp;
  logic              mem_req;
  logic [ADDR_W-1:0] mem_addr;
  logic              mem_ack;
  logic [WORD_W-1:0] mem_rdata;
  int                mem_beats;
  logic              mem_stuck;
  integer            seed;

  rdcache_top DUT (
    .clk_i           (clk),
    .rst_ni          (rst_n),
    .cache_en_i      (cache_en),
    .core_req_i      (core_req),
    .core_req_data_i (core_req_data),
    .core_ack_o      (core_ack),
    .core_rsp_o      (core_rsp),
    .mem_req_o       (mem_req),
    .mem_addr_o      (mem_addr),
    .mem_ack_i       (mem_ack),
    .mem_rdata_i     (mem_rdata)
  );

  tb_mem_model #(
    .SEED (SEED)
  ) i_mem (
    .clk_i       (clk),
    .mem_req_i   (mem_req),
    .mem_addr_i  (mem_addr),
    .mem_ack_o   (mem_ack),
    .mem_rdata_o (mem_rdata),
    .beats_o     (mem_beats),
    .stuck_o     (mem_stuck)
  );

  // 20 ns period
  always #10 clk = ~clk;

  ////////////////////
  // helpers
  ////////////////////

  task automatic report_timeout(input string what);
    $display("timeout at %0t while waiting for %s", $time, what);
    $display("SOME TESTS FAILED");
    $fatal(1, "simulation stopped on timeout");
  endtask

  // memory side hang
  always @(posedge clk) begin
    if (mem_stuck) begin
      report_timeout("mem_req_o to drop in the memory model");
    end
  end

  task automatic compare_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
    if (got !== exp) begin
      $display("[ERROR] %0t: %s: got %h, expected %h", $time, what, got, exp);
      $display("SOME TESTS FAILED");
      $fatal(1, "simulation stopped on mismatch");
    end
  endtask

  // what memory returns for a word address
  function automatic logic [WORD_W-1:0] pattern_word(input logic [ADDR_W-1:0] a);
    return {a, ~a};
  endfunction

  // one four-phase core read, latency in edges from the request
  task automatic core_read(input logic [ADDR_W-1:0] addr,
                           output logic [WORD_W-1:0] data, output int lat);
    int n;
    @(posedge clk);
    #2;
    core_req_data.addr = addr;
    core_req           = 1'b1;
    n = 0;
    do begin
      @(posedge clk);
      #1;
      n++;
    end while (!core_ack && n < TIMEOUT);
    if (!core_ack) begin
      report_timeout("core_ack_o to rise");
    end
    data = core_rsp.rdata;
    lat  = n;
    // release 2 ns after the edge
    #1;
    core_req = 1'b0;
    n = 0;
    do begin
      @(posedge clk);
      #1;
      n++;
    end while (core_ack && n < TIMEOUT);
    if (core_ack) begin
      report_timeout("core_ack_o to fall");
    end
  endtask

  // negative beat count skips the beat check
  task automatic read_and_check(input logic [ADDR_W-1:0] addr, input int exp_beats,
                                output int lat);
    logic [WORD_W-1:0] data;
    int                beats0;
    beats0 = mem_beats;
    core_read(addr, data, lat);
    compare_value($sformatf("read data at %h", addr), data, pattern_word(addr));
    if (exp_beats >= 0) begin
      compare_value($sformatf("beats for %h", addr), mem_beats - beats0, exp_beats);
    end
  endtask

  task automatic check_beat_addrs(input int first, input logic [ADDR_W-1:0] base,
                                  input int count);
    for (int k = 0; k < count; k++) begin
      compare_value($sformatf("beat %0d address", k),
                    i_mem.addr_log[(first + k) % 1024], base + k);
    end
  endtask

  ////////////////////
  // directed tests
  ////////////////////

  task automatic test_cold_miss();
    int beats0;
    int lat;
    beats0 = mem_beats;
    read_and_check(16'h0125, 4, lat);
    // whole line in offset order
    check_beat_addrs(beats0, 16'h0124, 4);
  endtask

  task automatic test_hit();
    int lat;
    read_and_check(16'h0126, 0, lat);
    compare_value("hit latency 0126", lat, 2);
    read_and_check(16'h0124, 0, lat);
    compare_value("hit latency 0124", lat, 2);
  endtask

  task automatic test_conflict();
    int beats0;
    int lat;
    // same index 9, other tag
    beats0 = mem_beats;
    read_and_check(16'h0524, 4, lat);
    check_beat_addrs(beats0, 16'h0524, 4);
    read_and_check(16'h0125, 4, lat);
  endtask

  task automatic test_noncacheable();
    int beats0;
    int lat;
    for (int i = 0; i < 2; i++) begin
      beats0 = mem_beats;
      read_and_check(16'h9001, 1, lat);
      check_beat_addrs(beats0, 16'h9001, 1);
    end
  endtask

  task automatic test_disabled();
    int beats0;
    int lat;
    @(posedge clk);
    #2;
    cache_en = 1'b0;
    // line of 0125 is resident, still one beat
    beats0 = mem_beats;
    read_and_check(16'h0125, 1, lat);
    check_beat_addrs(beats0, 16'h0125, 1);
    @(posedge clk);
    #2;
    cache_en = 1'b1;
  endtask

  task automatic test_random();
    logic [ADDR_W-1:0] addr;
    int                lat;
    for (int i = 0; i < 40; i++) begin
      addr = ADDR_W'($random(seed));
      read_and_check(addr, -1, lat);
    end
  endtask

  ////////////////////
  // main sequence
  ////////////////////

  initial begin
    seed               = SEED;
    clk                = 1'b0;
    rst_n              = 1'b0;
    cache_en           = 1'b1;
    core_req           = 1'b0;
    core_req_data.addr = '0;
    // reset held for 10 cycles
    repeat (10) @(posedge clk);
    #2;
    rst_n = 1'b1;
    test_cold_miss();
    test_hit();
    test_conflict();
    test_noncacheable();
    test_disabled();
    test_random();
    repeat (2) @(posedge clk);
    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

// ==== rdcache.f ====
hdl/rdcache_pkg.sv
hdl/rdcache_beat_cnt.sv
hdl/rdcache_array.sv
hdl/rdcache_ctrl.sv
hdl/rdcache_miss_unit.sv
hdl/rdcache_top.sv
testbench/tb_mem_model.sv
testbench/tb_rdcache.sv

// ==== Bender.yml ====
package:
  name: rdcache

sources:
  - files:
      - hdl/rdcache_pkg.sv
      - hdl/rdcache_beat_cnt.sv
      - hdl/rdcache_array.sv
      - hdl/rdcache_ctrl.sv
      - hdl/rdcache_miss_unit.sv
      - hdl/rdcache_top.sv
  - target: test
    files:
      - testbench/tb_mem_model.sv
      - testbench/tb_rdcache.sv
